// File: design/wr_pattern_pkg.sv
// Write data pattern source package with bus widths, size codes, run states and beat layout.
`default_nettype none

package wr_pattern_pkg;

    // Channel geometry.
    localparam int data_w = 256;
    localparam int lane_w = 32;
    localparam int lanes  = 8;
    localparam int strb_w = 32;                // One bit per byte.

    // Supported transfer size codes cover 4 to 32 bytes.
    localparam int size_min = 2;
    localparam int size_max = 5;

    // Low bits that always take part in wrapping.
    localparam int wrap_base_bits = 10;

    // Command field widths.
    localparam int beat_cnt_w = 40;
    localparam int len_w      = 8;

    // Run sequencing.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        RUN  = 2'd2,
        DONE = 2'd3
    } send_state_e;

    // One beat seen flat by the channel or lane by lane by the generator.
    typedef union packed {
        logic [data_w-1:0]             word;
        logic [lanes-1:0][lane_w-1:0]  lane;
    } beat_u;

endpackage

`default_nettype wire

// File: design/wr_beat_if.sv
// Beat handshake between the pattern generator and the channel register.
`timescale 1ns/10ps
`default_nettype none

interface wr_beat_if;
    import wr_pattern_pkg::*;

    logic               valid;
    logic               ready;
    beat_u              data;
    logic [strb_w-1:0]  strb;
    logic               last;

    modport src (
        output valid,
        output data,
        output strb,
        output last,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        input  strb,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// File: design/wr_cmd_ctrl.sv
// Command capture, run sequencing and owed beat budget for the write data source.
`timescale 1ns/10ps
`default_nettype none

module wr_cmd_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [wr_pattern_pkg::beat_cnt_w-1:0] total_beats,
    input  logic [2:0]                            wr_size,
    input  logic [wr_pattern_pkg::len_w-1:0]      wr_len,
    input  logic [wr_pattern_pkg::lane_w-1:0]     init_data,
    input  logic                                  wrap_mode,
    input  logic [3:0]                            wrap_len,
    input  logic                                  taken,
    output logic                                  load,
    output logic                                  run,
    output logic [2:0]                            cfg_size,
    output logic [wr_pattern_pkg::len_w-1:0]      cfg_len,
    output logic [wr_pattern_pkg::lane_w-1:0]     cfg_init,
    output logic                                  cfg_wrap_mode,
    output logic [3:0]                            cfg_wrap_len,
    output logic                                  busy,
    output logic                                  done
);
    import wr_pattern_pkg::*;

    send_state_e            state;
    send_state_e            state_nxt;
    logic [beat_cnt_w-1:0]  owed;
    logic                   accept;
    logic                   final_take;

    assign accept     = start && (state == IDLE);
    assign final_take = taken && (owed == beat_cnt_w'(1));

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (start)
                    state_nxt = LOAD;
            end
            LOAD:
            begin
                // Nothing owed means straight to completion.
                state_nxt = (owed == '0) ? DONE : RUN;
            end
            RUN:
            begin
                if (final_take || (owed == '0))
                    state_nxt = DONE;
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            owed <= '0;
        else if (accept)
            owed <= total_beats;
        else if (taken)
            owed <= owed - 1'b1;               // One beat handed off.
    end

    // Command fields are held for the whole run.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if ((wr_size < 3'(size_min)) || (wr_size > 3'(size_max)))
                cfg_size <= 3'(size_max);
            else
                cfg_size <= wr_size;
            cfg_len       <= wr_len;
            cfg_init      <= init_data;
            cfg_wrap_mode <= wrap_mode;
            cfg_wrap_len  <= wrap_len;
        end
    end

    assign load = (state == LOAD);
    assign run  = (state == RUN) && (owed != '0);
    assign busy = (state != IDLE);
    assign done = (state == DONE);

endmodule

`default_nettype wire

// File: design/wr_pattern_gen.sv
// Pattern generator that places incrementing lane values and strobes by transfer size.
`timescale 1ns/10ps
`default_nettype none

module wr_pattern_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  logic                               run,
    input  logic [2:0]                         cfg_size,
    input  logic [wr_pattern_pkg::len_w-1:0]   cfg_len,
    input  logic [wr_pattern_pkg::lane_w-1:0]  cfg_init,
    input  logic                               cfg_wrap_mode,
    input  logic [3:0]                         cfg_wrap_len,
    output logic                               taken,
    wr_beat_if.src                             beat
);
    import wr_pattern_pkg::*;

    logic [lane_w-1:0]  base;
    logic [2:0]         slot_cnt;
    logic [len_w-1:0]   burst_cnt;
    logic [1:0]         size_shift;
    logic [3:0]         lane_cnt;
    logic [2:0]         slot_mask;
    logic [3:0]         lane_off;
    logic [lane_w-1:0]  wrap_mask;
    logic [lane_w-1:0]  base_incr;
    logic [lane_w-1:0]  base_nxt;
    logic               beat_last;
    beat_u              beat_data;
    logic [strb_w-1:0]  beat_strb;

    // Size 2 gives one lane per beat, size 5 all eight.
    assign size_shift = 2'(cfg_size - 3'(size_min));
    assign lane_cnt   = 4'd1 << size_shift;
    assign slot_mask  = 3'b111 >> size_shift;
    assign lane_off   = {1'b0, slot_cnt & slot_mask} << size_shift;

    always_comb
    begin
        beat_data = '0;
        beat_strb = '0;
        for (int i = 0; i < lanes; i++)
        begin
            if ((i >= int'(lane_off)) && (i < int'(lane_off) + int'(lane_cnt)))
            begin
                beat_data.lane[i] = base + lane_w'(i) - lane_w'(lane_off);
                beat_strb[i*(strb_w/lanes) +: strb_w/lanes] = '1;
            end
        end
    end

    assign beat_last = (burst_cnt == '0);

    // Window covers wrap_base_bits plus wrap_len low bits.
    assign wrap_mask = (lane_w'(1) << (wrap_base_bits + int'(cfg_wrap_len))) - 1'b1;
    assign base_incr = base + lane_w'(lane_cnt);
    assign base_nxt  = cfg_wrap_mode ? ((base & ~wrap_mask) | (base_incr & wrap_mask))
                                     : base_incr;

    assign beat.valid = run;
    assign beat.data  = beat_data;
    assign beat.strb  = beat_strb;
    assign beat.last  = beat_last;

    assign taken = beat.valid && beat.ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            base      <= '0;
            slot_cnt  <= '0;
            burst_cnt <= '0;
        end
        else if (load)
        begin
            base      <= cfg_init;
            slot_cnt  <= '0;
            burst_cnt <= cfg_len;
        end
        else if (taken)
        begin
            base <= base_nxt;
            if (beat_last)
            begin
                slot_cnt  <= '0;               // Next burst starts at slot zero.
                burst_cnt <= cfg_len;
            end
            else
            begin
                slot_cnt  <= slot_cnt + 1'b1;
                burst_cnt <= burst_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/wr_beat_slice.sv
// Write channel output register that holds a beat under back-pressure.
`timescale 1ns/10ps
`default_nettype none

module wr_beat_slice (
    input  logic                               clk,
    input  logic                               rst_n,
    wr_beat_if.snk                             beat,
    input  logic                               wready,
    output logic                               wvalid,
    output logic [wr_pattern_pkg::data_w-1:0]  wdata,
    output logic [wr_pattern_pkg::strb_w-1:0]  wstrb,
    output logic                               wlast
);
    import wr_pattern_pkg::*;

    logic  load_beat;

    // Empty, or the held beat leaves this cycle.
    assign beat.ready = !wvalid || wready;
    assign load_beat  = beat.valid && beat.ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
        end
        else if (beat.ready)
        begin
            wvalid <= beat.valid;
            if (beat.valid)
                wlast <= beat.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_beat)
        begin
            wdata <= beat.data.word;
            wstrb <= beat.strb;
        end
    end

endmodule

`default_nettype wire

// File: design/wr_data_send_top.sv
// Write data pattern source top level with command, status and write channel ports.
`timescale 1ns/10ps
`default_nettype none

module wr_data_send_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    output logic [wr_pattern_pkg::data_w-1:0]     wdata,
    output logic [wr_pattern_pkg::strb_w-1:0]     wstrb,
    output logic                                  wvalid,
    output logic                                  wlast,
    input  logic                                  wready,
    input  logic                                  start,
    input  logic [wr_pattern_pkg::beat_cnt_w-1:0] total_beats,
    input  logic [2:0]                            wr_size,
    input  logic [wr_pattern_pkg::len_w-1:0]      wr_len,
    input  logic [wr_pattern_pkg::lane_w-1:0]     init_data,
    input  logic                                  wrap_mode,
    input  logic [3:0]                            wrap_len,
    output logic                                  busy,
    output logic                                  done
);
    import wr_pattern_pkg::*;

    logic               load;
    logic               run;
    logic               taken;
    logic [2:0]         cfg_size;
    logic [len_w-1:0]   cfg_len;
    logic [lane_w-1:0]  cfg_init;
    logic               cfg_wrap_mode;
    logic [3:0]         cfg_wrap_len;

    wr_beat_if i_beat_if ();

    wr_cmd_ctrl i_cmd_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .total_beats   (total_beats),
        .wr_size       (wr_size),
        .wr_len        (wr_len),
        .init_data     (init_data),
        .wrap_mode     (wrap_mode),
        .wrap_len      (wrap_len),
        .taken         (taken),
        .load          (load),
        .run           (run),
        .cfg_size      (cfg_size),
        .cfg_len       (cfg_len),
        .cfg_init      (cfg_init),
        .cfg_wrap_mode (cfg_wrap_mode),
        .cfg_wrap_len  (cfg_wrap_len),
        .busy          (busy),
        .done          (done)
    );

    wr_pattern_gen i_pattern_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .run           (run),
        .cfg_size      (cfg_size),
        .cfg_len       (cfg_len),
        .cfg_init      (cfg_init),
        .cfg_wrap_mode (cfg_wrap_mode),
        .cfg_wrap_len  (cfg_wrap_len),
        .taken         (taken),
        .beat          (i_beat_if.src)
    );

    wr_beat_slice i_beat_slice (
        .clk    (clk),
        .rst_n  (rst_n),
        .beat   (i_beat_if.snk),
        .wready (wready),
        .wvalid (wvalid),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wlast  (wlast)
    );

endmodule

`default_nettype wire

// File: dv/wr_data_send_checker.sv
// Bound assertions on the write channel handshake and the status outputs.
`timescale 1ns/10ps
`default_nettype none

module wr_data_send_checker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wvalid,
    input  logic                               wready,
    input  logic                               wlast,
    input  logic [wr_pattern_pkg::data_w-1:0]  wdata,
    input  logic [wr_pattern_pkg::strb_w-1:0]  wstrb,
    input  logic                               busy,
    input  logic                               done
);
    int fail_cnt = 0;

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast)))
        else
        begin
            fail_cnt++;
            $error("wvalid or the payload changed under back-pressure");
        end

    a_reset: assert property (@(posedge clk) !rst_n |-> (!wvalid && !wlast && !busy && !done))
        else
        begin
            fail_cnt++;
            $error("channel or status outputs active during reset");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else
        begin
            fail_cnt++;
            $error("done stayed high for more than one cycle");
        end

endmodule

`default_nettype wire

// File: dv/wr_beat_scoreboard.sv
// Scoreboard that models the expected beats of each command and checks every accepted beat.
`timescale 1ns/10ps
`default_nettype none

module wr_beat_scoreboard (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start,
    input  logic [wr_pattern_pkg::beat_cnt_w-1:0] total_beats,
    input  logic [2:0]                            wr_size,
    input  logic [wr_pattern_pkg::len_w-1:0]      wr_len,
    input  logic [wr_pattern_pkg::lane_w-1:0]     init_data,
    input  logic                                  wrap_mode,
    input  logic [3:0]                            wrap_len,
    input  logic                                  wvalid,
    input  logic                                  wready,
    input  logic [wr_pattern_pkg::data_w-1:0]     wdata,
    input  logic [wr_pattern_pkg::strb_w-1:0]     wstrb,
    input  logic                                  wlast,
    input  logic                                  busy,
    input  logic                                  done,
    output int                                    errors,
    output int                                    cmd_count,
    output int                                    beat_count,
    output int                                    done_count,
    output int                                    owed_beats
);
    import wr_pattern_pkg::*;

    typedef struct packed {
        logic [beat_cnt_w-1:0]  total;
        logic [2:0]             size;
        logic [len_w-1:0]       len;
        logic [lane_w-1:0]      init;
        logic                   wrap;
        logic [3:0]             wlen;
    } cmd_t;

    cmd_t               cmds[$];
    int                 idx;                   // Beats seen of the front command.
    logic [lane_w-1:0]  base;
    logic [data_w-1:0]  exp_data;
    logic [strb_w-1:0]  exp_strb;
    logic               exp_last;
    logic               exp_busy;              // High from the cycle after start to done.

    // Codes outside 2 to 5 behave like 32 bytes.
    function automatic int lanes_for(input logic [2:0] size);
        if ((int'(size) < size_min) || (int'(size) > size_max))
            return lanes;
        return 1 << (int'(size) - size_min);
    endfunction

    function automatic logic [lane_w-1:0] advance(input cmd_t c, input logic [lane_w-1:0] b,
                                                  input int n);
        longint window;
        longint low;
        if (!c.wrap)
            return b + lane_w'(n);
        window = longint'(1) << (wrap_base_bits + int'(c.wlen));
        low    = (longint'(b) % window + n) % window;
        return lane_w'(longint'(b) - longint'(b) % window + low);   // Upper bits kept.
    endfunction

    task automatic expect_beat(input cmd_t c);
        int n;
        int pos;
        int slot;
        n        = lanes_for(c.size);
        pos      = idx % (int'(c.len) + 1);
        slot     = pos % (lanes / n);
        exp_data = '0;
        exp_strb = '0;
        for (int k = 0; k < n; k++)
        begin
            exp_data[(slot*n+k)*lane_w +: lane_w] = base + lane_w'(k);
            exp_strb[(slot*n+k)*4 +: 4]           = 4'hf;
        end
        exp_last = (pos == int'(c.len));
    endtask

    function automatic int outstanding();
        int sum;
        sum = 0;
        foreach (cmds[i])
            sum += int'(cmds[i].total);
        return (cmds.size() == 0) ? 0 : sum - idx;
    endfunction

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            cmds.delete();
            idx        = 0;
            errors     = 0;
            cmd_count  = 0;
            beat_count = 0;
            done_count = 0;
            owed_beats = 0;
            exp_busy   = 1'b0;
        end
        else
        begin
            if (busy !== exp_busy)
            begin
                errors++;
                $display("mismatch at %0t: busy %b, expected %b", $time, busy, exp_busy);
            end
            if (start && !exp_busy)
            begin
                cmd_count++;
                exp_busy = 1'b1;
                if (total_beats != '0)
                    cmds.push_back({total_beats, wr_size, wr_len, init_data, wrap_mode, wrap_len});
            end
            if (wvalid && wready)
            begin
                beat_count++;
                if (cmds.size() == 0)
                begin
                    errors++;
                    $display("error at %0t: a beat was accepted with no command owing one", $time);
                end
                else
                begin
                    if (idx == 0)
                        base = cmds[0].init;
                    expect_beat(cmds[0]);
                    if (wdata !== exp_data)
                    begin
                        errors++;
                        $display("mismatch at %0t: beat %0d wdata %h, expected %h",
                                 $time, idx, wdata, exp_data);
                    end
                    if (wstrb !== exp_strb)
                    begin
                        errors++;
                        $display("mismatch at %0t: beat %0d wstrb %h, expected %h",
                                 $time, idx, wstrb, exp_strb);
                    end
                    if (wlast !== exp_last)
                    begin
                        errors++;
                        $display("mismatch at %0t: beat %0d wlast %b, expected %b",
                                 $time, idx, wlast, exp_last);
                    end
                    base = advance(cmds[0], base, lanes_for(cmds[0].size));
                    idx++;
                    if (idx == int'(cmds[0].total))
                    begin
                        cmds.delete(0);
                        idx = 0;
                    end
                end
            end
            // At most the held beat may still be on the channel.
            if (done)
            begin
                done_count++;
                exp_busy = 1'b0;
                if (outstanding() != ((wvalid && !wready) ? 1 : 0))
                begin
                    errors++;
                    $display("error at %0t: done pulsed with %0d beats still owed",
                             $time, outstanding());
                end
            end
            owed_beats = outstanding();
        end
    end

endmodule

`default_nettype wire

// File: dv/wr_data_send_tb.sv
// Testbench for the write data pattern source with random commands and random back-pressure.
`timescale 1ns/10ps
`default_nettype none

module wr_data_send_tb;
    import wr_pattern_pkg::*;

    localparam int num_cmds    = 40;
    localparam int max_beats   = 40;
    localparam int cycle_limit = num_cmds * (max_beats * 4 + 20);

    logic                   clk;
    logic                   rst_n;
    logic [data_w-1:0]      wdata;
    logic [strb_w-1:0]      wstrb;
    logic                   wvalid;
    logic                   wlast;
    logic                   wready;
    logic                   start;
    logic [beat_cnt_w-1:0]  total_beats;
    logic [2:0]             wr_size;
    logic [len_w-1:0]       wr_len;
    logic [lane_w-1:0]      init_data;
    logic                   wrap_mode;
    logic [3:0]             wrap_len;
    logic                   busy;
    logic                   done;

    int                     sb_errors;
    int                     cmd_count;
    int                     beat_count;
    int                     done_count;
    int                     owed_beats;
    int                     tb_errors = 0;
    int                     checker_fails;
    int                     cycles = 0;
    int unsigned            lcg_state = 24003;

    wr_data_send_top i_dut (.*);

    bind wr_data_send_top wr_data_send_checker i_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .wvalid (wvalid),
        .wready (wready),
        .wlast  (wlast),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .busy   (busy),
        .done   (done)
    );

    wr_beat_scoreboard i_scoreboard (
        .errors (sb_errors),
        .*
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;                 // Low bits cycle too fast.
    endfunction

    task automatic drive_ready();
        wready <= ((next_rand() % 10) < 7);
    endtask

    task automatic issue_command();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        @(posedge clk);
        start       <= 1'b1;
        wr_size     <= 3'(next_rand() % 8);
        wr_len      <= len_w'(next_rand() % 8);
        total_beats <= beat_cnt_w'(next_rand() % (max_beats + 1));
        init_data   <= {hi[15:0], lo[15:0]};
        wrap_mode   <= next_rand() % 2 == 1;
        wrap_len    <= 4'(next_rand() % 16);
        drive_ready();
        @(posedge clk);
        start <= 1'b0;
        drive_ready();
    endtask

    task automatic wait_done();
        do
        begin
            @(posedge clk);
            drive_ready();
        end
        while (!done);
    endtask

    task automatic check_totals();
        if (cmd_count != num_cmds)
        begin
            tb_errors++;
            $display("error: scoreboard saw %0d commands instead of %0d", cmd_count, num_cmds);
        end
        if (done_count != num_cmds)
        begin
            tb_errors++;
            $display("error: %0d done pulses for %0d commands", done_count, num_cmds);
        end
        if (owed_beats != 0)
        begin
            tb_errors++;
            $display("error: %0d expected beats never reached the channel", owed_beats);
        end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial
    begin
        rst_n       = 1'b0;
        start       = 1'b0;
        total_beats = '0;
        wr_size     = '0;
        wr_len      = '0;
        init_data   = '0;
        wrap_mode   = 1'b0;
        wrap_len    = '0;
        wready      = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int c = 0; c < num_cmds; c++)
        begin
            issue_command();
            wait_done();
        end
        @(posedge clk);
        wready <= 1'b1;                        // Drain the held beat.
        while (wvalid)
        begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        check_totals();
        checker_fails = i_dut.i_checker.fail_cnt;
        $display("errors: scoreboard %0d, checker %0d, testbench %0d; commands %0d, beats %0d",
                 sb_errors, checker_fails, tb_errors, cmd_count, beat_count);
        if (sb_errors + checker_fails + tb_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: wr_data_send.f
design/wr_pattern_pkg.sv
design/wr_beat_if.sv
design/wr_cmd_ctrl.sv
design/wr_pattern_gen.sv
design/wr_beat_slice.sv
design/wr_data_send_top.sv
dv/wr_data_send_checker.sv
dv/wr_beat_scoreboard.sv
dv/wr_data_send_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only if the pass line shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module wr_data_send_tb -f wr_data_send.f -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/Vwr_data_send_tb)
echo "$sim_out"
echo "$sim_out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
